// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fetch_tb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= sim passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== sources.f ====
+incdir+src
+incdir+tests
src/icache_pkg.sv
src/icache.sv
src/fetch_stage.sv
src/fetch_top.sv
tests/imem_model.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

// ==== src/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage (
  input  logic        clock,
  input  logic        reset,
  // cache lookup
  output logic [63:0] fetch_addr,
  input  logic        fetch_hit,
  input  logic [63:0] fetch_data,
  // redirect pulse from outside
  input  logic        redirect,
  input  logic [63:0] redirect_pc,
  // retired instruction
  output logic        inst_valid,
  output logic [63:0] inst_pc,
  output logic [63:0] inst_data
);

  logic [63:0] pc;
  logic        retire;

  // pc goes to the cache every cycle
  assign fetch_addr = pc;

  // redirect squashes a hit in the same cycle
  assign retire = fetch_hit && !redirect;

  // program counter
  always_ff @(posedge clock) begin
    if (reset) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (fetch_hit) begin
      // one 8-byte word per hit
      pc <= pc + 64'd8;
    end
  end

  // valid pulse one cycle after the hit
  always_ff @(posedge clock) begin
    if (reset) begin
      inst_valid <= 1'b0;
    end else begin
      inst_valid <= retire;
    end
  end

  // instruction payload, only meaningful with inst_valid
  always_ff @(posedge clock) begin
    if (retire) begin
      inst_pc   <= pc;
      inst_data <= fetch_data;
    end
  end

endmodule

// ==== src/fetch_top.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module fetch_top
  import icache_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  // redirect
  input  logic                     redirect,
  input  logic [63:0]              redirect_pc,
  // memory bus
  input  logic [`MEM_TAG_BITS-1:0] mem_response,
  input  logic [`MEM_TAG_BITS-1:0] mem_tag,
  input  logic [63:0]              mem_data,
  output bus_command_t             mem_command,
  output logic [63:0]              mem_addr,
  // retired instruction
  output logic                     inst_valid,
  output logic [63:0]              inst_pc,
  output logic [63:0]              inst_data
);

  // fetch to cache lookup
  logic [63:0] fetch_addr;
  logic [63:0] fetch_data;
  logic        fetch_hit;

  fetch_stage u_fetch_stage (
    .clock       (clock),
    .reset       (reset),
    .fetch_addr  (fetch_addr),
    .fetch_hit   (fetch_hit),
    .fetch_data  (fetch_data),
    .redirect    (redirect),
    .redirect_pc (redirect_pc),
    .inst_valid  (inst_valid),
    .inst_pc     (inst_pc),
    .inst_data   (inst_data)
  );

  icache u_icache (
    .clock        (clock),
    .reset        (reset),
    .fetch_addr   (fetch_addr),
    .fetch_data   (fetch_data),
    .fetch_hit    (fetch_hit),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_tag      (mem_tag),
    .mem_data     (mem_data)
  );

endmodule

// ==== src/icache.sv ====
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache
  import icache_pkg::*;
(
  input  logic                     clock,
  input  logic                     reset,
  // fetch side
  input  logic [63:0]              fetch_addr,
  output logic [63:0]              fetch_data,
  output logic                     fetch_hit,
  // tagged memory bus
  output bus_command_t             mem_command,
  output logic [63:0]              mem_addr,
  input  logic [`MEM_TAG_BITS-1:0] mem_response,
  input  logic [`MEM_TAG_BITS-1:0] mem_tag,
  input  logic [63:0]              mem_data
);

  // line storage and outstanding request table
  icache_entry_t  lines     [`ICACHE_LINES];
  mem_tag_entry_t tag_table [`MEM_TAGS];

  // head tracks the fetch index, tail runs ahead for prefetch
  logic [`ICACHE_IDX_BITS-1:0] head;
  logic [`ICACHE_IDX_BITS-1:0] tail;
  logic [`ICACHE_IDX_BITS-1:0] tail_plus_one;
  logic [`ICACHE_TAG_BITS-1:0] tail_tag;

  // fetch address split
  logic [`ICACHE_IDX_BITS-1:0] idx;
  logic [`ICACHE_TAG_BITS-1:0] tag;

  // lookup and request decisions
  logic                        hit;
  logic                        miss_pending;
  logic                        tail_pending;
  logic                        tail_present;
  logic                        tail_blocked;
  logic                        tail_advance;
  logic                        req_enable;
  logic                        req_valid;
  logic                        accepted;
  logic [`ICACHE_IDX_BITS-1:0] req_idx;
  logic [`ICACHE_TAG_BITS-1:0] req_tag;

  // fill path
  logic                        fill;
  logic [`ICACHE_IDX_BITS-1:0] fill_idx;
  logic [`ICACHE_TAG_BITS-1:0] fill_tag;

  // offset bits 2:0, then index, then tag
  assign idx = fetch_addr[`BLOCK_OFFSET_BITS +: `ICACHE_IDX_BITS];
  assign tag = fetch_addr[`BLOCK_OFFSET_BITS + `ICACHE_IDX_BITS +: `ICACHE_TAG_BITS];

  // direct-mapped lookup
  assign hit        = lines[idx].valid && (lines[idx].tag == tag);
  assign fetch_hit  = hit;
  assign fetch_data = lines[idx].data;

  // tail below the fetch index has wrapped into the next tag region
  assign tail_plus_one = tail + 1'b1;
  assign tail_tag      = (tail < idx) ? tag + 1'b1 : tag;

  // prefetch stops one line short of head
  assign tail_blocked = (tail_plus_one == head);
  assign tail_present = lines[tail].valid && (lines[tail].tag == tail_tag);

  // search the table for the missed block and the tail block
  always_comb begin
    miss_pending = 1'b0;
    tail_pending = 1'b0;
    // slot 0 is never used, tag 0 means busy or no data
    for (int i = 1; i < `MEM_TAGS; i++) begin
      if (tag_table[i].valid && tag_table[i].idx == idx && tag_table[i].tag == tag) begin
        miss_pending = 1'b1;
      end
      if (tag_table[i].valid && tag_table[i].idx == tail && tag_table[i].tag == tail_tag) begin
        tail_pending = 1'b1;
      end
    end
  end

  // miss asks for the fetch block, hit asks for the tail block
  always_comb begin
    if (hit) begin
      req_idx   = tail;
      req_tag   = tail_tag;
      req_valid = req_enable && !tail_present && !tail_pending && !tail_blocked;
    end else begin
      req_idx   = idx;
      req_tag   = tag;
      req_valid = req_enable && !miss_pending;
    end
  end

  // block address with zero offset, upper bits outside the used space
  assign mem_command = req_valid ? bus_load : bus_none;
  assign mem_addr    = {{(64 - `ADDR_BITS){1'b0}}, req_tag, req_idx,
                        {`BLOCK_OFFSET_BITS{1'b0}}};

  // nonzero response in the same cycle means the load got that tag
  assign accepted = req_valid && (mem_response != '0);

  // step past the tail line once it is present, pending or just accepted
  assign tail_advance = !tail_blocked && (tail_present || tail_pending || accepted);

  // fill only for a tag this cache is waiting on
  assign fill     = (mem_tag != '0) && tag_table[mem_tag].valid;
  assign fill_idx = tag_table[mem_tag].idx;
  assign fill_tag = tag_table[mem_tag].tag;

  // bus stays quiet until the first cycle out of reset
  always_ff @(posedge clock) begin
    if (reset) begin
      req_enable <= 1'b0;
    end else begin
      req_enable <= 1'b1;
    end
  end

  // head and tail pointers
  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      head <= idx;
      if (!hit) begin
        // restart prefetch just behind the missed line
        tail <= idx + 1'b1;
      end else if (tail_advance) begin
        tail <= tail_plus_one;
      end
    end
  end

  // outstanding request table
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `MEM_TAGS; i++) begin
        tag_table[i].valid <= 1'b0;
      end
    end else begin
      if (fill) begin
        tag_table[mem_tag].valid <= 1'b0;
      end
      // a tag reused in the fill cycle keeps the new request
      if (accepted) begin
        tag_table[mem_response] <= {1'b1, req_idx, req_tag};
      end
    end
  end

  // line storage, only valid bits are cleared
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `ICACHE_LINES; i++) begin
        lines[i].valid <= 1'b0;
      end
    end else begin
      // drop the stale line on a miss
      if (!hit) begin
        lines[idx].valid <= 1'b0;
      end
      // fill wins over the invalidate on the same line
      if (fill) begin
        lines[fill_idx] <= {1'b1, fill_tag, mem_data};
      end
    end
  end

endmodule

// ==== src/icache_defines.svh ====
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// number of direct-mapped lines, power of two
`define ICACHE_LINES 32

// used part of the fetch address
`define ADDR_BITS 16

// response tag values on the memory bus, tag 0 is no response
`define MEM_TAGS 16

// derived field widths
`define BLOCK_OFFSET_BITS 3
`define ICACHE_IDX_BITS $clog2(`ICACHE_LINES)
`define ICACHE_TAG_BITS (`ADDR_BITS - `ICACHE_IDX_BITS - `BLOCK_OFFSET_BITS)
`define MEM_TAG_BITS $clog2(`MEM_TAGS)

`endif

// ==== src/icache_pkg.sv ====
`include "icache_defines.svh"

package icache_pkg;

  // memory bus command, store exists on the bus but the cache never issues it
  typedef enum logic [1:0] {
    bus_none  = 2'h0,
    bus_load  = 2'h1,
    bus_store = 2'h2
  } bus_command_t;

  // one cache line
  typedef struct packed {
    logic                        valid;
    logic [`ICACHE_TAG_BITS-1:0] tag;
    logic [63:0]                 data;
  } icache_entry_t;

  // one outstanding load, slot number is the response tag
  typedef struct packed {
    logic                        valid;
    logic [`ICACHE_IDX_BITS-1:0] idx;
    logic [`ICACHE_TAG_BITS-1:0] tag;
  } mem_tag_entry_t;

endpackage

// ==== tests/tb_mem_rule.svh ====
`ifndef TB_MEM_RULE_SVH
`define TB_MEM_RULE_SVH

// memory word for a byte address, xor-rotate of the block number
function automatic logic [63:0] mem_word(input logic [63:0] addr);
  logic [63:0] x;
  x = {3'b000, addr[63:3]};
  x = x ^ {x[40:0], x[63:41]} ^ {x[18:0], x[63:19]} ^ 64'h9e37_79b9_7f4a_7c15;
  return x;
endfunction

`endif

// ==== tests/fetch_checker.sv ====
`timescale 1ns/1ps
`include "tb_mem_rule.svh"

module fetch_checker
  import icache_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  logic         busy,
  input  logic         redirect,
  input  logic [63:0]  redirect_pc,
  input  logic         inst_valid,
  input  logic [63:0]  inst_pc,
  input  logic [63:0]  inst_data,
  input  bus_command_t mem_command,
  input  logic [63:0]  mem_addr,
  input  logic [3:0]   mem_response,
  input  logic [3:0]   mem_tag,
  output int           mismatch_count,
  output int           protocol_count,
  output int           retired
);

  logic [63:0] expected_pc;
  logic [15:0] outstanding;
  // gap tracking for busy-free sequential stretches
  int          since_retire;
  int          streak;
  logic        quiet;

  initial begin
    mismatch_count = 0;
    protocol_count = 0;
    retired        = 0;
  end

  always @(posedge clock) begin
    if (reset) begin
      expected_pc  = 64'd0;
      outstanding  = '0;
      since_retire = 0;
      streak       = 0;
      quiet        = 1'b1;
      if (mem_command != bus_none) begin
        $display("error at %0t: memory command issued during reset", $time);
        protocol_count++;
      end
    end else begin
      since_retire++;
      if (inst_valid) begin
        retired++;
        if (inst_pc != expected_pc) begin
          $display("mismatch at %0t: pc %h, expected %h", $time, inst_pc, expected_pc);
          mismatch_count++;
        end
        if (inst_data != mem_word(inst_pc)) begin
          $display("mismatch at %0t: data %h at pc %h, expected %h",
                   $time, inst_data, inst_pc, mem_word(inst_pc));
          mismatch_count++;
        end
        // long busy-free run allows at most one idle cycle between retires
        if (quiet && streak >= 4 && since_retire > 2) begin
          $display("mismatch at %0t: gap of %0d cycles before pc %h",
                   $time, since_retire, inst_pc);
          mismatch_count++;
        end
        streak       = quiet ? streak + 1 : 1;
        quiet        = 1'b1;
        since_retire = 0;
        expected_pc  = inst_pc + 64'd8;
      end
      if (busy) begin
        quiet = 1'b0;
      end
      // anything retired after this point must start at the target
      if (redirect) begin
        expected_pc = redirect_pc;
        quiet       = 1'b0;
        streak      = 0;
      end
      if (mem_command == bus_load) begin
        if (mem_addr[2:0] != 3'd0 || mem_addr[63:16] != 48'd0) begin
          $display("error at %0t: load address %h is not a block address", $time, mem_addr);
          protocol_count++;
        end
      end
      if (mem_tag != 4'd0) begin
        if (!outstanding[mem_tag]) begin
          $display("error at %0t: data returned for tag %0d that was not outstanding",
                   $time, mem_tag);
          protocol_count++;
        end
        outstanding[mem_tag] = 1'b0;
      end
      if (mem_command == bus_load && mem_response != 4'd0) begin
        if ($countones(outstanding) >= 15) begin
          $display("error at %0t: load accepted with 15 tags outstanding", $time);
          protocol_count++;
        end
        if (outstanding[mem_response]) begin
          $display("error at %0t: tag %0d handed out twice", $time, mem_response);
          protocol_count++;
        end
        outstanding[mem_response] = 1'b1;
      end
    end
  end

endmodule

// ==== tests/fetch_tb.sv ====
`timescale 1ns/1ps

module fetch_tb
  import icache_pkg::*;
();

  localparam int FILL_LATENCY   = 6;
  localparam int INST_COUNT     = 2000;
  localparam int TIMEOUT_CYCLES = INST_COUNT * (FILL_LATENCY + 8) * 2;

  logic         clock;
  logic         reset;
  logic         busy;
  logic         redirect;
  logic [63:0]  redirect_pc;
  logic [3:0]   mem_response;
  logic [3:0]   mem_tag;
  logic [63:0]  mem_data;
  bus_command_t mem_command;
  logic [63:0]  mem_addr;
  logic         inst_valid;
  logic [63:0]  inst_pc;
  logic [63:0]  inst_data;
  int           mismatch_count;
  int           protocol_count;
  int           retired;
  int           cycles;
  logic [15:0]  lfsr_state;

  fetch_top uut (
    .clock        (clock),
    .reset        (reset),
    .redirect     (redirect),
    .redirect_pc  (redirect_pc),
    .mem_response (mem_response),
    .mem_tag      (mem_tag),
    .mem_data     (mem_data),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .inst_valid   (inst_valid),
    .inst_pc      (inst_pc),
    .inst_data    (inst_data)
  );

  imem_model #(.FILL_LATENCY(FILL_LATENCY)) memory (
    .clock        (clock),
    .reset        (reset),
    .busy         (busy),
    .mem_command  (mem_command),
    .mem_addr     (mem_addr),
    .mem_response (mem_response),
    .mem_tag      (mem_tag),
    .mem_data     (mem_data)
  );

  fetch_checker monitor (
    .clock          (clock),
    .reset          (reset),
    .busy           (busy),
    .redirect       (redirect),
    .redirect_pc    (redirect_pc),
    .inst_valid     (inst_valid),
    .inst_pc        (inst_pc),
    .inst_data      (inst_data),
    .mem_command    (mem_command),
    .mem_addr       (mem_addr),
    .mem_response   (mem_response),
    .mem_tag        (mem_tag),
    .mismatch_count (mismatch_count),
    .protocol_count (protocol_count),
    .retired        (retired)
  );

  // 16-bit fibonacci lfsr with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // one lfsr step per bit taken
  task automatic draw_bits(input int count, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value      = {value[30:0], lfsr_state[0]};
    end
  endtask

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    logic [31:0] r;
    lfsr_state  = 16'd28;
    reset       = 1'b1;
    busy        = 1'b0;
    redirect    = 1'b0;
    redirect_pc = 64'd0;
    cycles      = 0;
    repeat (3) @(posedge clock);
    #1 reset = 1'b0;
    while (retired < INST_COUNT && cycles < TIMEOUT_CYCLES) begin
      // memory busy one cycle in four
      draw_bits(2, r);
      busy = (r[1:0] == 2'b00);
      // redirect one cycle in 32 to an aligned target below 0x10000
      draw_bits(5, r);
      if (r[4:0] == 5'd0) begin
        draw_bits(13, r);
        redirect    = 1'b1;
        redirect_pc = {48'd0, r[12:0], 3'b000};
      end else begin
        redirect = 1'b0;
      end
      @(posedge clock);
      #1 cycles++;
    end
    redirect = 1'b0;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout: only %0d of %0d instructions retired in %0d cycles",
               retired, INST_COUNT, cycles);
    end
    $display("retired %0d, mismatch errors %0d, protocol errors %0d",
             retired, mismatch_count, protocol_count);
    if (cycles >= TIMEOUT_CYCLES || mismatch_count != 0 || protocol_count != 0) begin
      $display("sim failed");
    end else begin
      $display("sim passed");
    end
    $finish;
  end

endmodule

// ==== tests/imem_model.sv ====
`timescale 1ns/1ps
`include "tb_mem_rule.svh"

module imem_model
  import icache_pkg::*;
#(
  parameter int FILL_LATENCY = 6
) (
  input  logic         clock,
  input  logic         reset,
  input  logic         busy,
  input  bus_command_t mem_command,
  input  logic [63:0]  mem_addr,
  output logic [3:0]   mem_response,
  output logic [3:0]   mem_tag,
  output logic [63:0]  mem_data
);

  // tags handed out and not yet filled
  logic [15:0] in_use;
  // fixed latency delay line of tag and address
  logic [3:0]  pipe_tag  [FILL_LATENCY];
  logic [63:0] pipe_addr [FILL_LATENCY];

  // lowest free tag, zero when busy or full
  always_comb begin
    mem_response = 4'd0;
    if (mem_command == bus_load && !busy) begin
      for (int i = 15; i >= 1; i--) begin
        if (!in_use[i]) begin
          mem_response = 4'(i);
        end
      end
    end
  end

  assign mem_tag  = pipe_tag[FILL_LATENCY-1];
  assign mem_data = mem_word(pipe_addr[FILL_LATENCY-1]);

  always_ff @(posedge clock) begin
    if (reset) begin
      in_use <= '0;
      for (int i = 0; i < FILL_LATENCY; i++) begin
        pipe_tag[i]  <= 4'd0;
        pipe_addr[i] <= 64'd0;
      end
    end else begin
      pipe_tag[0]  <= mem_response;
      pipe_addr[0] <= mem_addr;
      for (int i = 1; i < FILL_LATENCY; i++) begin
        pipe_tag[i]  <= pipe_tag[i-1];
        pipe_addr[i] <= pipe_addr[i-1];
      end
      // tag free again after its data cycle
      if (mem_tag != 4'd0) begin
        in_use[mem_tag] <= 1'b0;
      end
      if (mem_response != 4'd0) begin
        in_use[mem_response] <= 1'b1;
      end
    end
  end

endmodule
